// ==== design/alu.sv ====
`timescale 1ns/100ps

module alu
(
	input  aluPkg::aluOp_t op,
	input  logic [aluPkg::dataWidth-1:0] a,
	input  logic [aluPkg::dataWidth-1:0] b,
	input  logic carryIn,
	output logic [aluPkg::dataWidth-1:0] result,
	output aluPkg::aluFlags_t flags
);

	import aluPkg::*;

	localparam int msb = dataWidth - 1;

	logic [dataWidth:0] sumWide;
	logic [dataWidth:0] sumCarryWide;
	logic [dataWidth-1:0] diff;
	logic addOverflow;
	logic subOverflow;
	logic unsignedLess;
	logic signedLess;
	logic equal;

	//////////////////////////////////////////////////////////////////////
	// Shared arithmetic
	//////////////////////////////////////////////////////////////////////

	assign sumWide = {1'b0, a} + {1'b0, b};
	assign sumCarryWide = sumWide + {{dataWidth{1'b0}}, carryIn};
	assign diff = a - b;

	// Same-sign operands giving a result of the other sign
	assign addOverflow = (a[msb] == b[msb]) && (sumWide[msb] != a[msb]);
	// a - b overflows only when the signs differ
	assign subOverflow = (a[msb] != b[msb]) && (diff[msb] != a[msb]);

	assign unsignedLess = a < b;
	assign signedLess = $signed(a) < $signed(b);
	assign equal = a == b;

	//////////////////////////////////////////////////////////////////////
	// Opcode select
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		result = '0;
		flags = '0;
		case (op)
			ADD, ADDI:
			begin
				result = sumWide[msb:0];
				flags.flag = addOverflow;
				flags.zero = ~|sumWide[msb:0];
			end
			ADDU, ADDUI:
			begin
				result = sumWide[msb:0];
				flags.carry = sumWide[dataWidth];
				flags.zero = ~|sumWide[msb:0];
			end
			ADDCU, ADDCUI:
			begin
				result = sumCarryWide[msb:0];
				flags.carry = sumCarryWide[dataWidth];
				flags.zero = ~|sumCarryWide[msb:0];
			end
			SUB, SUBI:
			begin
				result = diff;
				flags.flag = subOverflow;
				flags.zero = ~|diff;
			end
			// Compare leaves the result at zero
			CMP, CMPI:
			begin
				flags.low = unsignedLess;
				flags.negative = signedLess;
				flags.zero = equal;
			end
			AND, OR, XOR, NOT:
			begin
				case (op)
					AND:     result = a & b;
					OR:      result = a | b;
					XOR:     result = a ^ b;
					default: result = ~a;
				endcase
				flags.low = unsignedLess;
				flags.negative = signedLess;
				flags.zero = equal;
			end
			// Full shift amount, 16 and up clears the word
			LSH, LSHI, ALSH:
			begin
				result = a << b;
				flags.zero = ~|(a << b);
			end
			RSH, RSHI:
			begin
				result = a >> b;
				flags.zero = ~|(a >> b);
			end
			ARSH:
			begin
				result = $signed(a) >>> b;
				flags.zero = ~|($signed(a) >>> b);
			end
			default:
			begin
				result = '0;
				flags = '0;
			end
		endcase
	end

endmodule

// ==== design/aluPkg.sv ====
package aluPkg;

	// Word and register file geometry fixed by the instruction encoding
	localparam int dataWidth = 16;
	localparam int regAddrWidth = 4;
	localparam int regCount = 1 << regAddrWidth;

	// CR16-style opcodes, any code not listed here executes as NOP
	typedef enum logic [7:0]
	{
		NOP    = 8'h00,
		AND    = 8'h01,
		OR     = 8'h02,
		XOR    = 8'h03,
		NOT    = 8'h0F,
		ADD    = 8'h05,
		ADDU   = 8'h06,
		ADDCU  = 8'h07,
		SUB    = 8'h09,
		CMP    = 8'h0B,
		ADDI   = 8'h50,
		ADDUI  = 8'h60,
		ADDCUI = 8'h70,
		SUBI   = 8'h90,
		CMPI   = 8'hB0,
		LSHI   = 8'h80,
		RSHI   = 8'h81,
		LSH    = 8'h84,
		ALSH   = 8'h86,
		ARSH   = 8'h87,
		RSH    = 8'h8C
	} aluOp_t;

	typedef struct packed
	{
		aluOp_t opcode;
		logic [regAddrWidth-1:0] rDest;
		logic [regAddrWidth-1:0] rSrc;
		logic [7:0] imm;
	} instrWord_t;

	// Processor status register layout
	typedef struct packed
	{
		logic carry;
		logic flag;
		logic low;
		logic negative;
		logic zero;
	} aluFlags_t;

	// One instruction ready to execute
	typedef struct packed
	{
		aluOp_t op;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [regAddrWidth-1:0] rDest;
		logic valid;
	} execSlot_t;

	// True for every opcode that produces a result
	function automatic logic isExecOp(aluOp_t op);
		return op inside {ADD, ADDI, ADDU, ADDUI, ADDCU, ADDCUI, SUB, SUBI, CMP, CMPI,
			AND, OR, XOR, NOT, LSH, LSHI, RSH, RSHI, ALSH, ARSH};
	endfunction

	// Compares only update status
	function automatic logic writesRegister(aluOp_t op);
		return isExecOp(op) && !(op inside {CMP, CMPI});
	endfunction

endpackage

// ==== design/datapathTop.sv ====
`timescale 1ns/100ps

module datapathTop
(
	input  logic clk,
	input  logic reset,
	input  logic instrValid,
	input  aluPkg::instrWord_t instr,
	output logic resultValid,
	output logic [aluPkg::dataWidth-1:0] result,
	output logic [aluPkg::regAddrWidth-1:0] resultDest,
	output aluPkg::aluFlags_t status
);

	import aluPkg::*;

	logic [regAddrWidth-1:0] readAddrA;
	logic [regAddrWidth-1:0] readAddrB;
	logic [dataWidth-1:0] readDataA;
	logic [dataWidth-1:0] readDataB;
	execSlot_t slot;
	logic [dataWidth-1:0] aluResult;
	aluFlags_t aluFlags;
	logic writeEnable;
	logic [regAddrWidth-1:0] writeAddr;
	logic [dataWidth-1:0] writeData;

	//////////////////////////////////////////////////////////////////////
	// Decode and operand read
	//////////////////////////////////////////////////////////////////////

	instructionDecoder decoder
	(
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.wbWriteEnable(writeEnable),
		.wbWriteAddr(writeAddr),
		.wbWriteData(writeData),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.slot(slot)
	);

	registerFile regFile
	(
		.clk(clk),
		.reset(reset),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.writeAddr(writeAddr),
		.writeEnable(writeEnable),
		.writeData(writeData),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	//////////////////////////////////////////////////////////////////////
	// Execute and writeback
	//////////////////////////////////////////////////////////////////////

	// Add with carry uses the stored carry flag
	alu execUnit
	(
		.op(slot.op),
		.a(slot.a),
		.b(slot.b),
		.carryIn(status.carry),
		.result(aluResult),
		.flags(aluFlags)
	);

	writebackStage writeback
	(
		.clk(clk),
		.reset(reset),
		.slot(slot),
		.aluResult(aluResult),
		.aluFlags(aluFlags),
		.writeEnable(writeEnable),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.resultValid(resultValid),
		.result(result),
		.resultDest(resultDest),
		.status(status)
	);

endmodule

// ==== design/instructionDecoder.sv ====
`timescale 1ns/100ps

module instructionDecoder
(
	input  logic clk,
	input  logic reset,
	input  logic instrValid,
	input  aluPkg::instrWord_t instr,
	input  logic [aluPkg::dataWidth-1:0] readDataA,
	input  logic [aluPkg::dataWidth-1:0] readDataB,
	input  logic wbWriteEnable,
	input  logic [aluPkg::regAddrWidth-1:0] wbWriteAddr,
	input  logic [aluPkg::dataWidth-1:0] wbWriteData,
	output logic [aluPkg::regAddrWidth-1:0] readAddrA,
	output logic [aluPkg::regAddrWidth-1:0] readAddrB,
	output aluPkg::execSlot_t slot
);

	import aluPkg::*;

	logic [dataWidth-1:0] operandA;
	logic [dataWidth-1:0] regB;
	logic [dataWidth-1:0] operandB;
	logic bFromReg;
	execSlot_t slotReg;
	logic [regAddrWidth-1:0] slotAddrB;
	logic slotBFromReg;

	// A is always rDest, B is rSrc unless the opcode carries an immediate
	assign readAddrA = instr.rDest;
	assign readAddrB = instr.rSrc;

	// Write pending in the writeback stage lands at the same edge as this slot
	assign operandA = (wbWriteEnable && wbWriteAddr == readAddrA) ? wbWriteData : readDataA;
	assign regB = (wbWriteEnable && wbWriteAddr == readAddrB) ? wbWriteData : readDataB;

	//////////////////////////////////////////////////////////////////////
	// Immediate selection
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		bFromReg = 1'b1;
		operandB = regB;
		case (instr.opcode)
			ADDI, SUBI, CMPI:
			begin
				bFromReg = 1'b0;
				operandB = {{(dataWidth-8){instr.imm[7]}}, instr.imm};
			end
			ADDUI, ADDCUI, LSHI, RSHI:
			begin
				bFromReg = 1'b0;
				operandB = {{(dataWidth-8){1'b0}}, instr.imm};
			end
			default:
			begin
				bFromReg = 1'b1;
				operandB = regB;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Execute slot
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		slotReg.op <= instr.opcode;
		slotReg.a <= operandA;
		slotReg.b <= operandB;
		slotReg.rDest <= instr.rDest;
		slotAddrB <= instr.rSrc;
		slotBFromReg <= bFromReg;
		if (reset)
			slotReg.valid <= 1'b0;
		else
			slotReg.valid <= instrValid && isExecOp(instr.opcode);
	end

	// The instruction just ahead finishes at the edge that captured this slot
	// so its result is patched in after the register
	always_comb
	begin
		slot = slotReg;
		if (wbWriteEnable && wbWriteAddr == slotReg.rDest)
			slot.a = wbWriteData;
		if (slotBFromReg && wbWriteEnable && wbWriteAddr == slotAddrB)
			slot.b = wbWriteData;
	end

endmodule

// ==== design/registerFile.sv ====
`timescale 1ns/100ps

module registerFile
(
	input  logic clk,
	input  logic reset,
	input  logic [aluPkg::regAddrWidth-1:0] readAddrA,
	input  logic [aluPkg::regAddrWidth-1:0] readAddrB,
	input  logic [aluPkg::regAddrWidth-1:0] writeAddr,
	input  logic writeEnable,
	input  logic [aluPkg::dataWidth-1:0] writeData,
	output logic [aluPkg::dataWidth-1:0] readDataA,
	output logic [aluPkg::dataWidth-1:0] readDataB
);

	import aluPkg::*;

	logic [dataWidth-1:0] regs [regCount];

	// Every register starts at zero
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else if (writeEnable)
		begin
			regs[writeAddr] <= writeData;
		end
	end

	// Stored value only, forwarding lives in the decoder
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

// ==== design/writebackStage.sv ====
`timescale 1ns/100ps

module writebackStage
(
	input  logic clk,
	input  logic reset,
	input  aluPkg::execSlot_t slot,
	input  logic [aluPkg::dataWidth-1:0] aluResult,
	input  aluPkg::aluFlags_t aluFlags,
	output logic writeEnable,
	output logic [aluPkg::regAddrWidth-1:0] writeAddr,
	output logic [aluPkg::dataWidth-1:0] writeData,
	output logic resultValid,
	output logic [aluPkg::dataWidth-1:0] result,
	output logic [aluPkg::regAddrWidth-1:0] resultDest,
	output aluPkg::aluFlags_t status
);

	import aluPkg::*;

	logic [dataWidth-1:0] resultReg;
	logic [regAddrWidth-1:0] destReg;

	// Strobes and status register
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			writeEnable <= 1'b0;
			status <= '0;
		end
		else
		begin
			resultValid <= slot.valid;
			writeEnable <= slot.valid && writesRegister(slot.op);
			if (slot.valid)
				status <= aluFlags;
		end
	end

	// Holds the last result between strobes
	always_ff @(posedge clk)
	begin
		if (slot.valid)
		begin
			resultReg <= aluResult;
			destReg <= slot.rDest;
		end
	end

	// One register feeds the outside port, the register file and forwarding
	assign writeData = resultReg;
	assign writeAddr = destReg;
	assign result = resultReg;
	assign resultDest = destReg;

endmodule

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module datapathTb -o datapathSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/datapathSim)
runStatus=$?
echo "$output"
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1

// ==== sim/datapathProperties.sv ====
`timescale 1ns/100ps

module datapathProperties
(
	input  logic clk,
	input  logic reset,
	input  logic instrValid,
	input  aluPkg::instrWord_t instr,
	input  logic resultValid,
	input  aluPkg::aluFlags_t status
);

	import aluPkg::*;

	logic accepted;

	// NOP and unknown codes never produce a result
	assign accepted = instrValid && !reset && (instr.opcode inside {ADD, ADDI, ADDU, ADDUI,
		ADDCU, ADDCUI, SUB, SUBI, CMP, CMPI, AND, OR, XOR, NOT, LSH, LSHI, RSH, RSHI,
		ALSH, ARSH});

	quietAfterReset: assert property (@(posedge clk) $past(reset) |-> !resultValid)
		else $error("resultValid high in the cycle after reset");

	resultFollows: assert property (@(posedge clk) disable iff (reset)
		$past(accepted, 2) |-> resultValid)
		else $error("accepted instruction produced no resultValid");

	noStrayResult: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> $past(accepted, 2))
		else $error("resultValid without an accepted instruction");

	// Status only moves together with a result
	statusHeld: assert property (@(posedge clk) disable iff (reset)
		!resultValid |-> $stable(status))
		else $error("status changed with resultValid low");

endmodule

// ==== sim/datapathTb.sv ====
`timescale 1ns/100ps

module datapathTb;

	import aluPkg::*;

	logic clk;
	logic reset;
	logic instrValid;
	instrWord_t instr;
	logic resultValid;
	logic [dataWidth-1:0] result;
	logic [regAddrWidth-1:0] resultDest;
	aluFlags_t status;
	int errorCount;
	int checkCount;
	int outstanding;
	int errorsBase;
	int checksBase;
	int failedTests;
	int passedTests;
	logic timedOut;
	logic [15:0] lfsrState;
	logic [7:0] opPool[$];

	datapathTop uut
	(
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.resultValid(resultValid),
		.result(result),
		.resultDest(resultDest),
		.status(status)
	);

	resultChecker resultCheck
	(
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.resultValid(resultValid),
		.result(result),
		.resultDest(resultDest),
		.status(status),
		.errorCount(errorCount),
		.checkCount(checkCount),
		.outstanding(outstanding)
	);

	bind datapathTop datapathProperties props
	(
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.resultValid(resultValid),
		.status(status)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Galois form with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	task automatic drawBits(input int count, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[14:0], lfsrState[0]};
		end
	endtask

	task automatic issue(input logic [7:0] op, input logic [3:0] rd, input logic [3:0] rs,
		input logic [7:0] imm);
		if (!timedOut)
		begin
			@(posedge clk);
			#1;
			instrValid = 1'b1;
			instr = {op, rd, rs, imm};
		end
	endtask

	task automatic issueRandom(input int count, input logic [3:0] regMask);
		logic [15:0] pick;
		logic [15:0] rd;
		logic [15:0] rs;
		logic [15:0] imm;
		int idx;
		for (int n = 0; n < count; n++)
		begin
			drawBits(5, pick);
			drawBits(4, rd);
			drawBits(4, rs);
			drawBits(8, imm);
			idx = {16'h0000, pick} % opPool.size();
			issue(opPool[idx], rd[3:0] & regMask, rs[3:0] & regMask, imm[7:0]);
		end
	endtask

	// Builds a random word in every register a byte at a time
	task automatic loadRegisters();
		logic [15:0] bits;
		for (int r = 0; r < 16; r++)
		begin
			drawBits(16, bits);
			issue(XOR, r[3:0], r[3:0], 8'h00);
			issue(ADDUI, r[3:0], 4'h0, bits[15:8]);
			issue(LSHI, r[3:0], 4'h0, 8'd8);
			issue(ADDUI, r[3:0], 4'h0, bits[7:0]);
		end
	endtask

	task automatic finishTest(input string name);
		int waited;
		if (!timedOut)
		begin
			@(posedge clk);
			#1;
			instrValid = 1'b0;
			waited = 0;
			while (outstanding != 0 && waited < 20)
			begin
				@(posedge clk);
				waited++;
			end
			if (outstanding != 0)
			begin
				$display("Timeout in %s with %0d results never seen", name, outstanding);
				timedOut = 1'b1;
				failedTests++;
			end
			else
			begin
				if (errorCount == errorsBase)
					passedTests++;
				else
					failedTests++;
				$display("Test %-18s %4d results  %0d errors", name, checkCount - checksBase,
					errorCount - errorsBase);
				errorsBase = errorCount;
				checksBase = checkCount;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [15:0] amount;
		logic [15:0] bits;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		lfsrState = 16'd61131;
		errorsBase = 0;
		checksBase = 0;
		failedTests = 0;
		passedTests = 0;
		timedOut = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int r = 0; r < 16; r++)
			issue(ADDI, r[3:0], 4'h0, 8'h00);
		finishTest("reset");

		loadRegisters();
		opPool = '{ADD, ADDU, SUB, ADDI, ADDUI, SUBI};
		issueRandom(60, 4'hF);
		finishTest("arithmetic");

		for (int n = 0; n < 16; n++)
		begin
			drawBits(16, bits);
			issue(ADDU, bits[3:0], bits[7:4], 8'h00);
			issue(bits[8] ? ADDCU : ADDCUI, bits[11:8], bits[15:12], bits[15:8]);
		end
		finishTest("carry chain");

		loadRegisters();
		opPool = '{CMP, CMPI, AND, OR, XOR, NOT};
		issueRandom(40, 4'hF);
		// Read back the compared register
		issue(CMP, 4'd3, 4'd5, 8'h00);
		issue(ADDI, 4'd3, 4'h0, 8'h00);
		finishTest("compare and logic");

		loadRegisters();
		opPool = '{LSH, RSH, ALSH, ARSH, LSHI, RSHI};
		for (int n = 0; n < 24; n++)
		begin
			drawBits(5, amount);
			drawBits(5, bits);
			issue(XOR, 4'hF, 4'hF, 8'h00);
			issue(ADDUI, 4'hF, 4'h0, {3'b000, amount[4:0]});
			issue(opPool[bits[1:0]], {1'b0, bits[4:2]}, 4'hF, 8'h00);
			issueRandom(2, 4'hF);
		end
		finishTest("shifts");

		loadRegisters();
		opPool = '{ADD, SUB, ADDU, ADDCU, ADDI, SUBI, AND, XOR, NOT, LSH, RSHI, ARSH, CMP,
			NOP, 8'hEE, 8'h3C};
		issueRandom(60, 4'h1);
		finishTest("dependent and NOP");

		repeat (3) @(posedge clk);
		$display("Summary: %0d tests passed, %0d failed, %0d results, %0d errors",
			passedTests, failedTests, checkCount, errorCount);
		if (!timedOut && errorCount == 0 && failedTests == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== sim/resultChecker.sv ====
`timescale 1ns/100ps

module resultChecker
(
	input  logic clk,
	input  logic reset,
	input  logic instrValid,
	input  aluPkg::instrWord_t instr,
	input  logic resultValid,
	input  logic [aluPkg::dataWidth-1:0] result,
	input  logic [aluPkg::regAddrWidth-1:0] resultDest,
	input  aluPkg::aluFlags_t status,
	output int errorCount,
	output int checkCount,
	output int outstanding
);

	import aluPkg::*;

	typedef struct packed
	{
		logic valid;
		logic [15:0] value;
		logic [3:0] dest;
		aluFlags_t flags;
	} expect_t;

	logic [15:0] regModel [16];
	aluFlags_t statusModel;
	aluFlags_t committedStatus;
	expect_t nearSlot;
	expect_t farSlot;

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		outstanding = 0;
	end

	task automatic mismatch(input string msg);
		errorCount++;
		$display("MISMATCH at %0t ns: %s", $time, msg);
	endtask

	task automatic fault(input string msg);
		errorCount++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	function automatic logic yieldsResult(input logic [7:0] op);
		return op inside {ADD, ADDI, ADDU, ADDUI, ADDCU, ADDCUI, SUB, SUBI, CMP, CMPI,
			AND, OR, XOR, NOT, LSH, LSHI, RSH, RSHI, ALSH, ARSH};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference ALU, integer arithmetic on widened operands
	//////////////////////////////////////////////////////////////////////

	function automatic void predict(input logic [7:0] op, input logic [15:0] a,
		input logic [15:0] b, input logic carryIn, output logic [15:0] value,
		output aluFlags_t fl);
		int ua;
		int ub;
		int sa;
		int sb;
		int wide;
		ua = {16'h0000, a};
		ub = {16'h0000, b};
		sa = {{16{a[15]}}, a};
		sb = {{16{b[15]}}, b};
		value = '0;
		fl = '0;
		case (op)
			ADD, ADDI, SUB, SUBI:
			begin
				wide = (op == ADD || op == ADDI) ? sa + sb : sa - sb;
				value = wide[15:0];
				fl.flag = (wide > 32767) || (wide < -32768);
			end
			ADDU, ADDUI, ADDCU, ADDCUI:
			begin
				wide = ua + ub;
				if (op == ADDCU || op == ADDCUI)
					wide = wide + (carryIn ? 1 : 0);
				value = wide[15:0];
				fl.carry = wide > 65535;
			end
			CMP, CMPI, AND, OR, XOR, NOT:
			begin
				if (op == AND)
					value = a & b;
				else if (op == OR)
					value = a | b;
				else if (op == XOR)
					value = a ^ b;
				else if (op == NOT)
					value = ~a;
				fl.low = ua < ub;
				fl.negative = sa < sb;
				fl.zero = a == b;
			end
			LSH, LSHI, ALSH:
				value = (ub >= 16) ? 16'h0000 : a << ub;
			RSH, RSHI:
				value = (ub >= 16) ? 16'h0000 : a >> ub;
			ARSH:
			begin
				wide = sa >>> ((ub >= 16) ? 16 : ub);
				value = wide[15:0];
			end
			default:
				value = '0;
		endcase
		// Zero tracks the result except for compares and logic
		if (!(op inside {CMP, CMPI, AND, OR, XOR, NOT}))
			fl.zero = value == 16'h0000;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare on the falling edge, where every port is settled
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		logic [15:0] operandB;
		logic [15:0] value;
		aluFlags_t fl;
		if (reset)
		begin
			for (int i = 0; i < 16; i++)
				regModel[i] = '0;
			statusModel = '0;
			committedStatus = '0;
			nearSlot = '0;
			farSlot = '0;
			outstanding = 0;
			if (resultValid !== 1'b0 || status !== '0)
				mismatch($sformatf("in reset resultValid %b status %b", resultValid, status));
		end
		else
		begin
			// Result seen now was accepted two falling edges ago
			if (farSlot.valid)
			begin
				checkCount++;
				outstanding--;
				if (resultValid !== 1'b1)
					fault($sformatf("no resultValid for the result to r%0d", farSlot.dest));
				else if (result !== farSlot.value || resultDest !== farSlot.dest)
					mismatch($sformatf("r%0d = %h, expected r%0d = %h", resultDest, result,
						farSlot.dest, farSlot.value));
				committedStatus = farSlot.flags;
			end
			else if (resultValid !== 1'b0)
				fault("resultValid raised with no instruction to answer");
			if (status !== committedStatus)
				mismatch($sformatf("status %b, expected %b", status, committedStatus));
			farSlot = nearSlot;
			nearSlot = '0;
			if (instrValid && yieldsResult(instr.opcode))
			begin
				case (instr.opcode)
					ADDI, SUBI, CMPI:
						operandB = {{8{instr.imm[7]}}, instr.imm};
					ADDUI, ADDCUI, LSHI, RSHI:
						operandB = {8'h00, instr.imm};
					default:
						operandB = regModel[instr.rSrc];
				endcase
				predict(instr.opcode, regModel[instr.rDest], operandB, statusModel.carry,
					value, fl);
				nearSlot = {1'b1, value, instr.rDest, fl};
				statusModel = fl;
				if (!(instr.opcode inside {CMP, CMPI}))
					regModel[instr.rDest] = value;
				outstanding++;
			end
		end
	end

endmodule

// ==== sources.f ====
design/aluPkg.sv
design/registerFile.sv
design/instructionDecoder.sv
design/alu.sv
design/writebackStage.sv
design/datapathTop.sv
sim/datapathProperties.sv
sim/resultChecker.sv
sim/datapathTb.sv
